/* pe_subsys.f */
+incdir+source
source/pe_pkg.sv
source/pe_ctrl_if.sv
source/pe_fsm.sv
source/window_select.sv
source/layer_sort.sv
source/priority_eval.sv
source/pe_top.sv
verification/pe_clock_gen.sv
verification/pe_props.sv
verification/pe_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the priority evaluator testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module pe_tb \
    -f pe_subsys.f \
    --Mdir obj_dir \
    -o pe_sim

# a $fatal or a failed assertion gives a non-zero exit status
./obj_dir/pe_sim

/* source/layer_sort.sv */
`timescale 1ns/1ps
`include "pe_params.svh"

module layer_sort import pe_pkg::*; (
    input  bg_pixels_t               bg,
    input  obj_pixel_t               obj,
    input  logic [`PE_LAYER_CNT-1:0] layer_en,
    output layer_id_t                first_id,
    output layer_id_t                second_id,
    output pal_index_t               first_index,
    output pal_index_t               second_index
);

    // sort key is {priority, 1 for BG} so OBJ wins a tie, top bit marks an empty slot
    logic [`PE_LAYER_CNT-1:0] cand;
    logic [3:0]               key [`PE_LAYER_CNT];
    pal_index_t               idx [`PE_LAYER_CNT];

    always_comb begin
        for (int i = 0; i < `PE_LAYER_CNT - 1; i++) begin
            cand[i] = bg[5*i+4] & layer_en[i];
            key[i]  = {1'b0, 2'(i), 1'b1};
            idx[i]  = {4'(i), bg[5*i +: 4]};   // 16 entries per BG
        end
        cand[`PE_LAYER_CNT-1] = obj[`PE_OBJ_OPAQUE] & layer_en[`PE_LAYER_CNT-1];
        key[`PE_LAYER_CNT-1]  = {1'b0, obj[`PE_OBJ_PRIO_LSB +: 2], 1'b0};
        idx[`PE_LAYER_CNT-1]  = obj[`PE_OBJ_INDEX_LSB +: `PE_INDEX_W];
    end

    // insertion into a two-deep list, the backdrop holds any slot left empty
    always_comb begin
        logic [3:0] best_key;
        logic [3:0] next_key;

        best_key     = 4'b1000;
        next_key     = 4'b1000;
        first_id     = LAYER_BACKDROP;
        second_id    = LAYER_BACKDROP;
        first_index  = '0;
        second_index = '0;
        for (int k = 0; k < `PE_LAYER_CNT; k++) begin
            if (cand[k]) begin
                if (key[k] < best_key) begin
                    next_key     = best_key;
                    second_id    = first_id;
                    second_index = first_index;
                    best_key     = key[k];
                    first_id     = layer_id_t'(k);
                    first_index  = idx[k];
                end else if (key[k] < next_key) begin
                    next_key     = key[k];
                    second_id    = layer_id_t'(k);
                    second_index = idx[k];
                end
            end
        end
    end

endmodule

/* source/pe_ctrl_if.sv */
`timescale 1ns/1ps

interface pe_ctrl_if import pe_pkg::*; ();

    logic   clear;
    logic   eval;
    logic   send_address_1;
    logic   read_data_1;
    logic   send_address_2;
    logic   read_data_2;
    coord_t col;   // column of the pixel being worked on

    modport seq (
        output clear, eval, send_address_1, read_data_1,
        output send_address_2, read_data_2, col
    );

    modport dp (
        input clear, eval, send_address_1, read_data_1,
        input send_address_2, read_data_2, col
    );

endinterface

/* source/pe_fsm.sv */
`timescale 1ns/1ps
`include "pe_params.svh"

module pe_fsm import pe_pkg::*; (
    input  logic   clock,
    input  logic   arst_n,
    pe_ctrl_if.seq ctrl
);

    pe_state_t state;
    pe_state_t state_next;
    coord_t    col;
    logic      last_col;

    assign last_col = (col == coord_t'(`PE_SCREEN_W - 1));

    always_comb begin
        case (state)
            CLEAR:   state_next = EVAL;
            EVAL:    state_next = SEND1;
            SEND1:   state_next = READ1;
            READ1:   state_next = SEND2;
            SEND2:   state_next = READ2;
            READ2:   state_next = last_col ? CLEAR : EVAL;   // one CLEAR cycle per line
            default: state_next = CLEAR;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= CLEAR;
        end else begin
            state <= state_next;
        end
    end

    // the column moves on once the second color of a pixel is read
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            col <= '0;
        end else if (state == CLEAR) begin
            col <= '0;
        end else if (state == READ2) begin
            col <= last_col ? '0 : col + 1'b1;
        end
    end

    assign ctrl.clear          = (state == CLEAR);
    assign ctrl.eval           = (state == EVAL);
    assign ctrl.send_address_1 = (state == SEND1);
    assign ctrl.read_data_1    = (state == READ1);
    assign ctrl.send_address_2 = (state == SEND2);
    assign ctrl.read_data_2    = (state == READ2);
    assign ctrl.col            = col;

endmodule

/* source/pe_params.svh */
`ifndef PE_PARAMS_SVH
`define PE_PARAMS_SVH

// screen geometry
`define PE_SCREEN_W   240
`define PE_LAST_ROW   227

// bus and field widths
`define PE_PAL_W      32
`define PE_REG_W      16
`define PE_COORD_W    8
`define PE_COLOR_W    15
`define PE_LAYER_W    3
`define PE_EFFECTS_W  5
`define PE_INDEX_W    8
`define PE_BG_W       20
`define PE_OBJ_W      20
`define PE_LAYER_CNT  5   // BG0 to BG3 and OBJ

// fields of an object pixel, counted from bit 0
`define PE_OBJ_OPAQUE    19
`define PE_OBJ_PRIO_LSB  17
`define PE_OBJ_SEMI      16
`define PE_OBJ_WIN       15
`define PE_OBJ_INDEX_LSB 7

`endif

/* source/pe_pkg.sv */
`include "pe_params.svh"

package pe_pkg;

    // four 5-bit entries, entry i is {opaque, color index[3:0]} for BG i
    typedef logic [`PE_BG_W-1:0] bg_pixels_t;

    // {opaque, priority[1:0], semi, obj window, index[7:0], unused[6:0]}
    typedef logic [`PE_OBJ_W-1:0] obj_pixel_t;

    typedef logic [`PE_REG_W-1:0] reg16_t;
    typedef logic [`PE_COORD_W-1:0] coord_t;
    typedef logic [`PE_COLOR_W-1:0] color_t;   // RGB555
    typedef logic [`PE_LAYER_W-1:0] layer_id_t;
    typedef logic [`PE_INDEX_W-1:0] pal_index_t;
    typedef logic [`PE_PAL_W-1:0] pal_word_t;

    // {second is backdrop, front is semi OBJ, effect enable, region[1:0]}
    typedef logic [`PE_EFFECTS_W-1:0] effects_t;

    typedef enum logic [2:0] {
        CLEAR,
        EVAL,
        SEND1,
        READ1,
        SEND2,
        READ2
    } pe_state_t;

    localparam layer_id_t LAYER_OBJ      = 3'd4;
    localparam layer_id_t LAYER_BACKDROP = 3'd5;

    localparam logic [1:0] REGION_WIN0    = 2'd0;
    localparam logic [1:0] REGION_WIN1    = 2'd1;
    localparam logic [1:0] REGION_OBJWIN  = 2'd2;
    localparam logic [1:0] REGION_OUTSIDE = 2'd3;

endpackage

/* source/pe_top.sv */
`timescale 1ns/1ps
`include "pe_params.svh"

module pe_top import pe_pkg::*; (
    input  logic                 clock,
    input  logic                 arst_n,
    input  bg_pixels_t           BG,
    input  obj_pixel_t           OBJ,
    input  reg16_t               dispcnt,
    input  reg16_t               winin,
    input  reg16_t               winout,
    input  reg16_t               win0H,
    input  reg16_t               win1H,
    input  reg16_t               win0V,
    input  reg16_t               win1V,
    input  coord_t               vcount,
    input  pal_word_t            gfx_palette_bg_data,
    input  pal_word_t            gfx_palette_obj_data,
    output logic [`PE_PAL_W-1:0] gfx_palette_bg_addr,
    output logic [`PE_PAL_W-1:0] gfx_palette_obj_addr,
    output color_t               pe_color0,
    output color_t               pe_color1,
    output layer_id_t            pe_layer0,
    output layer_id_t            pe_layer1,
    output effects_t             pe_effects,
    output logic                 pe_pixel_valid
);

    coord_t               pe_row;
    pal_word_t            pe_data;
    logic [`PE_PAL_W-1:0] pe_addr;
    logic                 addr_is_obj;

    pe_ctrl_if ctrl ();

    // the line being drawn is the one after vcount
    assign pe_row = (vcount == coord_t'(`PE_LAST_ROW)) ? '0 : vcount + 1'b1;

    assign pe_data              = addr_is_obj ? gfx_palette_obj_data : gfx_palette_bg_data;
    assign gfx_palette_bg_addr  = pe_addr;
    assign gfx_palette_obj_addr = pe_addr;   // same entry, only the data select differs

    pe_fsm fsm (
        .clock,
        .arst_n,
        .ctrl(ctrl.seq)
    );

    priority_eval datapath (
        .clk(clock), .arst_n,
        .ctrl(ctrl.dp),
        .BG, .OBJ,
        .dispcnt, .winin, .winout,
        .win0H, .win1H, .win0V, .win1V,
        .row(pe_row),
        .data(pe_data),
        .address(pe_addr),
        .addr_is_obj,
        .color0(pe_color0), .color1(pe_color1),
        .layer0(pe_layer0), .layer1(pe_layer1),
        .effects(pe_effects),
        .pixel_valid(pe_pixel_valid)
    );

endmodule

/* source/priority_eval.sv */
`timescale 1ns/1ps
`include "pe_params.svh"

module priority_eval import pe_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n,
    pe_ctrl_if.dp                ctrl,
    input  bg_pixels_t           BG,
    input  obj_pixel_t           OBJ,
    input  reg16_t               dispcnt,
    input  reg16_t               winin,
    input  reg16_t               winout,
    input  reg16_t               win0H,
    input  reg16_t               win1H,
    input  reg16_t               win0V,
    input  reg16_t               win1V,
    input  coord_t               row,
    input  pal_word_t            data,
    output logic [`PE_PAL_W-1:0] address,
    output logic                 addr_is_obj,
    output color_t               color0,
    output color_t               color1,
    output layer_id_t            layer0,
    output layer_id_t            layer1,
    output effects_t             effects,
    output logic                 pixel_valid
);

    logic [`PE_LAYER_CNT-1:0] layer_en;
    logic [1:0]               region;
    logic                     effect_en;
    layer_id_t                first_id;
    layer_id_t                second_id;
    pal_index_t               first_index;
    pal_index_t               second_index;

    layer_id_t  id0_q;
    layer_id_t  id1_q;
    pal_index_t index0_q;
    pal_index_t index1_q;
    effects_t   effects_q;
    color_t     color0_q;

    window_select u_window (
        .col(ctrl.col), .row, .dispcnt, .winin, .winout,
        .win0H, .win1H, .win0V, .win1V,
        .obj_win(OBJ[`PE_OBJ_WIN]),
        .layer_en, .region, .effect_en
    );

    layer_sort u_sort (
        .bg(BG), .obj(OBJ), .layer_en,
        .first_id, .second_id, .first_index, .second_index
    );

    always_ff @(posedge clk) begin
        if (ctrl.eval) begin
            id0_q     <= first_id;
            id1_q     <= second_id;
            index0_q  <= first_index;
            index1_q  <= second_index;
            effects_q <= {second_id == LAYER_BACKDROP,
                          (first_id == LAYER_OBJ) && OBJ[`PE_OBJ_SEMI],
                          effect_en, region};
        end
        if (ctrl.read_data_1) begin
            color0_q <= data[`PE_COLOR_W-1:0];
        end
    end

    // one shared palette port, the front entry goes out first
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            address     <= '0;
            addr_is_obj <= 1'b0;
        end else if (ctrl.clear) begin
            address     <= '0;
            addr_is_obj <= 1'b0;
        end else if (ctrl.send_address_1) begin
            address     <= pal_word_t'(index0_q);
            addr_is_obj <= (id0_q == LAYER_OBJ);   // backdrop reads BG entry 0
        end else if (ctrl.send_address_2) begin
            address     <= pal_word_t'(index1_q);
            addr_is_obj <= (id1_q == LAYER_OBJ);
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.read_data_2) begin
            color0  <= color0_q;
            color1  <= data[`PE_COLOR_W-1:0];
            layer0  <= id0_q;
            layer1  <= id1_q;
            effects <= effects_q;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pixel_valid <= 1'b0;
        end else begin
            pixel_valid <= ctrl.read_data_2;
        end
    end

endmodule

/* source/window_select.sv */
`timescale 1ns/1ps
`include "pe_params.svh"

module window_select import pe_pkg::*; (
    input  coord_t                   col,
    input  coord_t                   row,
    input  reg16_t                   dispcnt,
    input  reg16_t                   winin,
    input  reg16_t                   winout,
    input  reg16_t                   win0H,
    input  reg16_t                   win1H,
    input  reg16_t                   win0V,
    input  reg16_t                   win1V,
    input  logic                     obj_win,
    output logic [`PE_LAYER_CNT-1:0] layer_en,
    output logic [1:0]               region,
    output logic                     effect_en
);

    logic [`PE_LAYER_CNT-1:0] disp_en;
    logic [`PE_LAYER_CNT:0]   mask;   // layer enables with the effect enable on top
    logic                     in_win0;
    logic                     in_win1;

    // high byte is the left or top edge, low byte the right or bottom edge (exclusive)
    function automatic logic in_window(coord_t c, coord_t r, reg16_t h, reg16_t v);
        return (c >= h[15:8]) && (c < h[7:0]) && (r >= v[15:8]) && (r < v[7:0]);
    endfunction

    assign disp_en = dispcnt[12:8];
    assign in_win0 = in_window(col, row, win0H, win0V);
    assign in_win1 = in_window(col, row, win1H, win1V);

    always_comb begin
        region = REGION_OUTSIDE;
        mask   = winout[5:0];
        if (dispcnt[15:13] == 3'b000) begin
            mask = '1;   // windowing off so everything enabled shows
        end else if (dispcnt[13] && in_win0) begin
            region = REGION_WIN0;
            mask   = winin[5:0];
        end else if (dispcnt[14] && in_win1) begin
            region = REGION_WIN1;
            mask   = winin[13:8];
        end else if (dispcnt[15] && obj_win) begin
            region = REGION_OBJWIN;
            mask   = winout[13:8];
        end
    end

    assign layer_en  = mask[`PE_LAYER_CNT-1:0] & disp_en;
    assign effect_en = mask[`PE_LAYER_CNT];

endmodule

/* verification/pe_clock_gen.sv */
`timescale 1ns/1ps

module pe_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 3
) (
    output logic clock,
    output logic arst_n
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2) clock = ~clock;
    end

    // release on a falling edge, well away from the active edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
    end

endmodule

/* verification/pe_props.sv */
`timescale 1ns/1ps
`include "pe_params.svh"

module pe_props (
    input logic                 clock,
    input logic                 arst_n,
    input logic                 pe_pixel_valid,
    input logic [`PE_PAL_W-1:0] addr,
    input logic                 read1,
    input logic                 read2
);

    // one pulse per pixel, never two in a row
    valid_single_a: assert property (@(posedge clock) disable iff (!arst_n)
        pe_pixel_valid |=> !pe_pixel_valid)
        else $error("pixel valid high on two consecutive cycles");

    valid_after_reset_a: assert property (@(posedge clock) $rose(arst_n) |-> !pe_pixel_valid)
        else $error("pixel valid high right after reset");

    // the address must not move at the edge where the palette data is captured
    addr_stable_a: assert property (@(posedge clock) disable iff (!arst_n)
        (read1 || read2) |=> $stable(addr))
        else $error("palette address changed during a read cycle");

endmodule

bind pe_top pe_props props_i (
    .clock,
    .arst_n,
    .pe_pixel_valid,
    .addr(gfx_palette_bg_addr),
    .read1(ctrl.read_data_1),
    .read2(ctrl.read_data_2)
);

/* verification/pe_tb.sv */
`timescale 1ns/1ps
`include "pe_params.svh"

module pe_tb import pe_pkg::*; ();

    localparam int     LINES      = 6;
    localparam int     PIXELS     = LINES * `PE_SCREEN_W;
    localparam longint TIMEOUT_NS = longint'(LINES) * 1201 * 40 * 3 / 2;

    typedef struct packed {
        color_t    c0;
        color_t    c1;
        layer_id_t l0;
        layer_id_t l1;
        effects_t  fx;
        coord_t    col;
    } expect_t;

    logic       clock;
    logic       arst_n;
    bg_pixels_t BG = '0;
    obj_pixel_t OBJ = '0;
    reg16_t     dispcnt = '0;
    reg16_t     winin = '0;
    reg16_t     winout = '0;
    reg16_t     win0H = '0;
    reg16_t     win1H = '0;
    reg16_t     win0V = '0;
    reg16_t     win1V = '0;
    coord_t     vcount = '0;
    pal_word_t  bg_data = '0;
    pal_word_t  obj_data = '0;
    logic [`PE_PAL_W-1:0] bg_addr;
    logic [`PE_PAL_W-1:0] obj_addr;
    color_t     color0;
    color_t     color1;
    layer_id_t  layer0;
    layer_id_t  layer1;
    effects_t   effects;
    logic       pixel_valid;

    pal_word_t   bg_pal [256];
    pal_word_t   obj_pal [256];
    expect_t     exp_q[$];
    string       name_q[$];
    string       test_name = "reset";
    int          checked = 0;
    longint      cycle = 0;
    longint      last_cycle = 0;

    pe_clock_gen clk_gen (.clock, .arst_n);

    pe_top dut_i (
        .clock, .arst_n,
        .BG, .OBJ,
        .dispcnt, .winin, .winout,
        .win0H, .win1H, .win0V, .win1V,
        .vcount,
        .gfx_palette_bg_data(bg_data),
        .gfx_palette_obj_data(obj_data),
        .gfx_palette_bg_addr(bg_addr),
        .gfx_palette_obj_addr(obj_addr),
        .pe_color0(color0), .pe_color1(color1),
        .pe_layer0(layer0), .pe_layer1(layer1),
        .pe_effects(effects),
        .pe_pixel_valid(pixel_valid)
    );

    // palette models answer on the falling edge after the address shows up
    always @(negedge clock) begin
        bg_data  <= bg_pal[bg_addr[7:0]];
        obj_data <= obj_pal[obj_addr[7:0]];
    end

    always @(posedge clock) cycle <= cycle + 1;

    task automatic fail_run(string why);
        $display("TESTBENCH FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check_color(string name, color_t exp, color_t act);
        if (exp !== act) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            fail_run("color mismatch");
        end
    endtask

    task automatic check_layer(string name, layer_id_t exp, layer_id_t act);
        if (exp !== act) begin
            $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
            fail_run("layer id mismatch");
        end
    endtask

    task automatic check_effects(string name, effects_t exp, effects_t act);
        if (exp !== act) begin
            $display("ERROR %s: expected %b, actual %b", name, exp, act);
            fail_run("effects mismatch");
        end
    endtask

    task automatic check_gap(string name, int exp, int act);
        if (exp != act) begin
            $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
            fail_run("valid pulse spacing mismatch");
        end
    endtask

    function automatic logic in_win(coord_t c, coord_t r, reg16_t h, reg16_t v);
        return (c >= h[15:8]) && (c < h[7:0]) && (r >= v[15:8]) && (r < v[7:0]);
    endfunction

    // expected result of one pixel from the current inputs and palettes
    function automatic expect_t ref_pixel(coord_t col);
        coord_t     row;
        logic [5:0] mask;
        logic [1:0] region;
        logic [4:0] en;
        layer_id_t  ids [2];
        logic [7:0] idx [2];
        int         n;
        expect_t    e;

        row = (vcount == 8'(`PE_LAST_ROW)) ? 8'd0 : vcount + 8'd1;
        if (dispcnt[15:13] == 3'b000) begin
            region = 2'd3;
            mask   = 6'h3f;
        end else if (dispcnt[13] && in_win(col, row, win0H, win0V)) begin
            region = 2'd0;
            mask   = winin[5:0];
        end else if (dispcnt[14] && in_win(col, row, win1H, win1V)) begin
            region = 2'd1;
            mask   = winin[13:8];
        end else if (dispcnt[15] && OBJ[15]) begin
            region = 2'd2;
            mask   = winout[13:8];
        end else begin
            region = 2'd3;
            mask   = winout[5:0];
        end
        en = mask[4:0] & dispcnt[12:8];

        // walk priority levels front to back, OBJ before the BG of equal priority
        ids[0] = LAYER_BACKDROP;
        ids[1] = LAYER_BACKDROP;
        idx[0] = 8'd0;
        idx[1] = 8'd0;
        n = 0;
        for (int p = 0; p < 4; p++) begin
            if (OBJ[19] && en[4] && OBJ[18:17] == 2'(p) && n < 2) begin
                ids[n] = LAYER_OBJ;
                idx[n] = OBJ[14:7];
                n++;
            end
            if (BG[5*p+4] && en[p] && n < 2) begin
                ids[n] = layer_id_t'(p);
                idx[n] = {4'(p), BG[5*p +: 4]};
                n++;
            end
        end

        e.c0  = (ids[0] == LAYER_OBJ) ? obj_pal[idx[0]][14:0] : bg_pal[idx[0]][14:0];
        e.c1  = (ids[1] == LAYER_OBJ) ? obj_pal[idx[1]][14:0] : bg_pal[idx[1]][14:0];
        e.l0  = ids[0];
        e.l1  = ids[1];
        e.fx  = {ids[1] == LAYER_BACKDROP, (ids[0] == LAYER_OBJ) && OBJ[16], mask[5], region};
        e.col = col;
        return e;
    endfunction

    task automatic set_line(int line);
        int l0;
        int l1;

        case (line)
            0: begin
                test_name = "priority";
                vcount    = 8'd10;
            end
            1, 2, 3: begin
                test_name = "win01";
                vcount    = (line == 1) ? 8'd100 : (line == 2) ? 8'd226 : 8'd227;
            end
            4: begin
                test_name = "objwin";
                vcount    = 8'd50;
            end
            default: begin
                test_name = "effects";
                vcount    = 8'd150;
            end
        endcase
        l0 = int'($urandom % 200);
        l1 = int'($urandom % 200);
        win0H  = {8'(l0), 8'(l0 + 1 + int'($urandom % 40))};
        win1H  = {8'(l1), 8'(l1 + 1 + int'($urandom % 60))};
        win0V  = {8'($urandom % 120), 8'(120 + $urandom % 110)};
        win1V  = {8'($urandom % 60), 8'(60 + $urandom % 170)};
        winin  = 16'($urandom);
        winout = 16'($urandom);
        if (line == 1) begin
            win1V = {8'd101, 8'(120 + $urandom % 100)};   // top edge on the drawn row
        end else if (line == 3) begin
            win0V[15:8] = 8'd0;   // the drawn row wraps to the top line here
        end
    endtask

    task automatic drive_pixel(int line, int col);
        int k;

        if (col == 0) set_line(line);
        BG  = 20'($urandom);
        OBJ = 20'($urandom);
        case (line)
            0:       dispcnt = {3'b000, 5'($urandom), 8'h00};
            1, 2, 3: dispcnt = {3'b011, 5'($urandom), 8'h00};
            4:       dispcnt = {3'b101, 5'($urandom), 8'h00};
            default: begin
                dispcnt = 16'h1f00;
                if (col % 2 == 0) begin
                    OBJ[19:16] = 4'b1001;   // opaque, priority 0, semi-transparent
                end else begin
                    k  = int'($urandom % 5);   // a single opaque layer
                    BG = '0;
                    if (k < 4) begin
                        BG[5*k +: 5] = {1'b1, 4'($urandom)};
                        OBJ = '0;
                    end else begin
                        OBJ[19] = 1'b1;
                    end
                end
            end
        endcase
        exp_q.push_back(ref_pixel(coord_t'(col)));
        name_q.push_back(test_name);
    endtask

    task automatic wait_pulse();
        @(negedge clock);
        while (!pixel_valid) @(negedge clock);
    endtask

    always @(negedge clock) begin
        expect_t e;
        string   nm;

        if (arst_n && pixel_valid) begin
            if (exp_q.size() == 0) begin
                fail_run("pixel valid pulse with no pixel outstanding");
            end else begin
                e  = exp_q.pop_front();
                nm = name_q.pop_front();
                if (checked > 0) begin
                    check_gap({nm, " gap"}, (e.col == 8'd0) ? 6 : 5, int'(cycle - last_cycle));
                end
                last_cycle = cycle;
                check_layer({nm, " layer0"}, e.l0, layer0);
                check_layer({nm, " layer1"}, e.l1, layer1);
                check_color({nm, " color0"}, e.c0, color0);
                check_color({nm, " color1"}, e.c1, color1);
                check_effects({nm, " effects"}, e.fx, effects);
                checked++;
            end
        end
    end

    initial begin
        void'($urandom(30971));
        for (int i = 0; i < 256; i++) begin
            bg_pal[i]  = $urandom;
            obj_pal[i] = $urandom;
        end
        @(negedge clock);
        for (int line = 0; line < LINES; line++) begin
            for (int col = 0; col < `PE_SCREEN_W; col++) begin
                if (line != 0 || col != 0) wait_pulse();
                drive_pixel(line, col);
            end
        end
        wait (checked == PIXELS);
        $display("TESTBENCH PASSED");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: only %0d of %0d pixels were reported", checked, PIXELS);
        fail_run("watchdog expired");
    end

endmodule
